//--- filelist.f
hw/axi4_ram_pkg.sv
hw/axi4_wr_arbiter.sv
hw/axi4_rd_arbiter.sv
hw/axi4_ram_slave.sv
hw/axi4_ram_subsystem.sv
verif/axi4_ram_subsystem_assert.sv
verif/tb_axi4_ram_subsystem.sv

//--- Bender.yml
package:
  name: axi4_ram_subsystem

sources:
  # RTL in compile order
  - files:
      - hw/axi4_ram_pkg.sv
      - hw/axi4_wr_arbiter.sv
      - hw/axi4_rd_arbiter.sv
      - hw/axi4_ram_slave.sv
      - hw/axi4_ram_subsystem.sv

  # Verification sources
  - target: simulation
    files:
      - verif/axi4_ram_subsystem_assert.sv
      - verif/tb_axi4_ram_subsystem.sv

//--- verif/tb_axi4_ram_subsystem.sv
// Directed testbench with master-side burst tasks, a reference memory and the final report
module tb_axi4_ram_subsystem;

  logic clk;
  logic rst_n;

  // Master-side buses with one slice per master
  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::addr_width-1:0] awaddr;
  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::len_width-1:0]  awlen;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               awvalid;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               awready;
  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::data_width-1:0] wdata;
  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::strb_width-1:0] wstrb;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               wlast;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               wvalid;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               wready;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               bvalid;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               bready;
  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::addr_width-1:0] araddr;
  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::len_width-1:0]  arlen;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               arvalid;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               arready;
  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::data_width-1:0] rdata;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               rlast;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               rvalid;
  logic [axi4_ram_pkg::nr_of_masters-1:0]                               rready;

  // Expected RAM contents kept in step with every accepted W beat
  logic [axi4_ram_pkg::data_width-1:0] ref_mem [axi4_ram_pkg::ram_words];
  int b_count [axi4_ram_pkg::nr_of_masters];
  int seed = 32'h391d;

  axi4_ram_subsystem axi4_ram_subsystem_i (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Count B handshakes per master in the low phase after the drivers
  always @(negedge clk) begin
    #2;
    for (int i = 0; i < axi4_ram_pkg::nr_of_masters; i++) begin
      if (bvalid[i] && bready[i]) begin
        b_count[i] = b_count[i] + 1;
      end
    end
  end

  // Bus rule failures from the bound checker
  always @(negedge clk) begin
    if (axi4_ram_subsystem_i.axi4_ram_subsystem_assert_i.fail_count != 0) begin
      stop_on_error("bus rule assertion failed on the master ports");
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // Advance one cycle and give up after 200
  task automatic wait_tick(inout int t, input string what);
    @(negedge clk);
    t++;
    if (t > 200) begin
      stop_on_error($sformatf("timeout waiting for %s", what));
    end
  endtask

  function automatic logic draw_rready(input logic stall);
    int v;
    v = 1;
    if (stall) begin
      v = $random(seed);
    end
    return v[0];
  endfunction

  // ----------------------------------------------------------------------
  // Master-side bursts
  // ----------------------------------------------------------------------
  task automatic write_burst(input int m,
                             input logic [axi4_ram_pkg::addr_width-1:0] addr,
                             input logic [axi4_ram_pkg::len_width-1:0] len,
                             input logic [axi4_ram_pkg::data_width-1:0] data,
                             input logic [axi4_ram_pkg::strb_width-1:0] strb);
    int t;
    int idx;
    logic [axi4_ram_pkg::data_width-1:0] beat;
    @(negedge clk);
    awaddr[m]  = addr;
    awlen[m]   = len;
    awvalid[m] = 1'b1;
    t = 0;
    #1;
    // Grant latency varies with the scan pointer
    while (!awready[m]) begin
      wait_tick(t, "awready");
      #1;
    end
    @(negedge clk);
    awvalid[m] = 1'b0;
    // Word index from byte address bits 7..2
    idx = addr[axi4_ram_pkg::addr_width-1:2];
    for (int k = 0; k <= len; k++) begin
      beat      = data + 32'h01010101 * k;
      wdata[m]  = beat;
      wstrb[m]  = strb;
      wlast[m]  = (k == len);
      wvalid[m] = 1'b1;
      t = 0;
      #1;
      while (!wready[m]) begin
        wait_tick(t, "wready");
        #1;
      end
      // Beat taken on the coming edge so the strobed bytes go to the reference
      for (int b = 0; b < axi4_ram_pkg::strb_width; b++) begin
        if (strb[b]) begin
          ref_mem[idx][8*b +: 8] = beat[8*b +: 8];
        end
      end
      idx = (idx + 1) % axi4_ram_pkg::ram_words;
      @(negedge clk);
    end
    wvalid[m] = 1'b0;
    wlast[m]  = 1'b0;
    bready[m] = 1'b1;
    t = 0;
    #1;
    while (!bvalid[m]) begin
      wait_tick(t, "bvalid");
      #1;
    end
    @(negedge clk);
    bready[m] = 1'b0;
  endtask

  task automatic read_burst(input int m,
                            input logic [axi4_ram_pkg::addr_width-1:0] addr,
                            input logic [axi4_ram_pkg::len_width-1:0] len,
                            input logic stall);
    int t;
    int idx;
    @(negedge clk);
    araddr[m]  = addr;
    arlen[m]   = len;
    arvalid[m] = 1'b1;
    t = 0;
    #1;
    while (!arready[m]) begin
      wait_tick(t, "arready");
      #1;
    end
    @(negedge clk);
    arvalid[m] = 1'b0;
    idx = addr[axi4_ram_pkg::addr_width-1:2];
    for (int k = 0; k <= len; k++) begin
      t = 0;
      rready[m] = draw_rready(stall);
      #1;
      while (!(rvalid[m] && rready[m])) begin
        wait_tick(t, "rvalid");
        rready[m] = draw_rready(stall);
        #1;
      end
      assert (rdata[m] == ref_mem[idx])
        else stop_on_error($sformatf("mismatch rdata expected %h actual %h",
                                     ref_mem[idx], rdata[m]));
      // Last flag on beat len only
      assert (rlast[m] == (k == len))
        else stop_on_error($sformatf("mismatch rlast beat %0d expected %h actual %h",
                                     k, (k == len), rlast[m]));
      idx = (idx + 1) % axi4_ram_pkg::ram_words;
      @(negedge clk);
    end
    rready[m] = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic check_reset_idle();
    @(negedge clk);
    #1;
    assert (awready == '0)
      else stop_on_error($sformatf("mismatch awready expected 0 actual %h", awready));
    assert (wready == '0)
      else stop_on_error($sformatf("mismatch wready expected 0 actual %h", wready));
    assert (bvalid == '0)
      else stop_on_error($sformatf("mismatch bvalid expected 0 actual %h", bvalid));
    assert (arready == '0)
      else stop_on_error($sformatf("mismatch arready expected 0 actual %h", arready));
    assert (rvalid == '0)
      else stop_on_error($sformatf("mismatch rvalid expected 0 actual %h", rvalid));
  endtask

  task automatic single_master_roundtrip();
    logic [axi4_ram_pkg::data_width-1:0] d;
    d = $random(seed);
    b_count[0] = 0;
    write_burst(0, 8'h00, 8'd3, d, 4'hf);
    assert (b_count[0] == 1)
      else stop_on_error($sformatf("mismatch b_count expected 1 actual %h", b_count[0]));
    read_burst(0, 8'h00, 8'd3, 1'b0);
  endtask

  // Four masters write distinct regions at once and a neighbour reads each back
  task automatic all_masters_contend();
    logic [axi4_ram_pkg::data_width-1:0] d [axi4_ram_pkg::nr_of_masters];
    for (int i = 0; i < axi4_ram_pkg::nr_of_masters; i++) begin
      d[i]       = $random(seed);
      b_count[i] = 0;
    end
    fork
      write_burst(0, 8'h20, 8'd3, d[0], 4'hf);
      write_burst(1, 8'h40, 8'd3, d[1], 4'hf);
      write_burst(2, 8'h60, 8'd3, d[2], 4'hf);
      write_burst(3, 8'h80, 8'd3, d[3], 4'hf);
    join
    for (int i = 0; i < axi4_ram_pkg::nr_of_masters; i++) begin
      assert (b_count[i] == 1)
        else stop_on_error($sformatf("mismatch b_count expected 1 actual %h", b_count[i]));
      read_burst((i + 1) % axi4_ram_pkg::nr_of_masters, 32 * (i + 1), 8'd3, 1'b0);
    end
  endtask

  task automatic partial_strobe_write();
    logic [axi4_ram_pkg::data_width-1:0] a;
    logic [axi4_ram_pkg::data_width-1:0] b;
    a = $random(seed);
    b = $random(seed);
    write_burst(1, 8'ha0, 8'd0, a, 4'hf);
    // Only bytes 0 and 2 of the second word land
    write_burst(2, 8'ha0, 8'd0, b, 4'b0101);
    read_burst(3, 8'ha0, 8'd0, 1'b0);
  endtask

  task automatic stalled_read();
    logic [axi4_ram_pkg::data_width-1:0] d;
    d = $random(seed);
    write_burst(2, 8'hc0, 8'd7, d, 4'hf);
    read_burst(3, 8'hc0, 8'd7, 1'b0);
    read_burst(3, 8'hc0, 8'd7, 1'b1);
  endtask

  task automatic overlapped_wr_rd();
    logic [axi4_ram_pkg::data_width-1:0] d0;
    logic [axi4_ram_pkg::data_width-1:0] d1;
    d0 = $random(seed);
    d1 = $random(seed);
    // Prefill words 62, 63, 0, 1
    write_burst(3, 8'hf8, 8'd3, d0, 4'hf);
    fork
      write_burst(1, 8'h50, 8'd3, d1, 4'hf);
      read_burst(2, 8'hf8, 8'd3, 1'b1);
    join
    read_burst(0, 8'h50, 8'd3, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_n   = 1'b0;
    awaddr  = '0;
    awlen   = '0;
    awvalid = '0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = '0;
    wvalid  = '0;
    bready  = '0;
    araddr  = '0;
    arlen   = '0;
    arvalid = '0;
    rready  = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_reset_idle();
    single_master_roundtrip();
    all_masters_contend();
    partial_strobe_write();
    stalled_read();
    overlapped_wr_rd();
    if (axi4_ram_subsystem_i.axi4_ram_subsystem_assert_i.fail_count != 0) begin
      stop_on_error("bus rule assertion failed on the master ports");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- verif/axi4_ram_subsystem_assert.sv
// Concurrent AXI handshake rules on the master-side ports of the RAM subsystem
module axi4_ram_subsystem_assert (
  input logic                                    clk,
  input logic                                    rst_n,
  input logic [axi4_ram_pkg::nr_of_masters-1:0] awready,
  input logic [axi4_ram_pkg::nr_of_masters-1:0] wready,
  input logic [axi4_ram_pkg::nr_of_masters-1:0] bvalid,
  input logic [axi4_ram_pkg::nr_of_masters-1:0] bready,
  input logic [axi4_ram_pkg::nr_of_masters-1:0] arready,
  input logic [axi4_ram_pkg::nr_of_masters-1:0] rlast,
  input logic [axi4_ram_pkg::nr_of_masters-1:0] rvalid,
  input logic [axi4_ram_pkg::nr_of_masters-1:0] rready
);

  // Count of failed bus rules
  int fail_count = 0;

  // ----------------------------------------------------------------------
  // Exclusive grants
  // ----------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(awready))
    else begin
      fail_count++;
      $error("awready high for more than one master");
    end
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wready))
    else begin
      fail_count++;
      $error("wready high for more than one master");
    end
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(bvalid))
    else begin
      fail_count++;
      $error("bvalid high for more than one master");
    end
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(arready))
    else begin
      fail_count++;
      $error("arready high for more than one master");
    end
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rvalid))
    else begin
      fail_count++;
      $error("rvalid high for more than one master");
    end

  // Broadcast rlast needs a valid beat at some master
  assert property (@(posedge clk) disable iff (!rst_n) (|rlast) |-> (|rvalid))
    else begin
      fail_count++;
      $error("rlast high without rvalid");
    end

  // Raised valids hold until their ready
  for (genvar i = 0; i < axi4_ram_pkg::nr_of_masters; i++) begin : g_hold
    assert property (@(posedge clk) disable iff (!rst_n)
      bvalid[i] && !bready[i] |=> bvalid[i])
      else begin
        fail_count++;
        $error("bvalid dropped before bready on master %0d", i);
      end
    assert property (@(posedge clk) disable iff (!rst_n)
      rvalid[i] && !rready[i] |=> rvalid[i])
      else begin
        fail_count++;
        $error("rvalid dropped before rready on master %0d", i);
      end
  end

endmodule

bind axi4_ram_subsystem axi4_ram_subsystem_assert axi4_ram_subsystem_assert_i (.*);

//--- hw/axi4_ram_subsystem.sv
// Top level joining the write arbiter, the read arbiter and the shared RAM
module axi4_ram_subsystem (
  input  logic clk,
  input  logic rst_n,

  // AW
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::addr_width-1:0] awaddr,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::len_width-1:0]  awlen,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               awvalid,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               awready,
  // W
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::data_width-1:0] wdata,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::strb_width-1:0] wstrb,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               wlast,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               wvalid,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               wready,
  // B
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               bvalid,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               bready,
  // AR
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::addr_width-1:0] araddr,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::len_width-1:0]  arlen,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               arvalid,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               arready,
  // R
  output logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::data_width-1:0] rdata,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               rlast,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               rvalid,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               rready
);

  // ----------------------------------------------------------------------
  // Internal write bus
  // ----------------------------------------------------------------------
  logic [axi4_ram_pkg::addr_width-1:0] ram_awaddr;
  logic [axi4_ram_pkg::len_width-1:0]  ram_awlen;
  logic                                ram_awvalid;
  logic                                ram_awready;
  logic [axi4_ram_pkg::data_width-1:0] ram_wdata;
  logic [axi4_ram_pkg::strb_width-1:0] ram_wstrb;
  logic                                ram_wlast;
  logic                                ram_wvalid;
  logic                                ram_wready;
  logic                                ram_bvalid;
  logic                                ram_bready;

  // ----------------------------------------------------------------------
  // Internal read bus
  // ----------------------------------------------------------------------
  logic [axi4_ram_pkg::addr_width-1:0] ram_araddr;
  logic [axi4_ram_pkg::len_width-1:0]  ram_arlen;
  logic                                ram_arvalid;
  logic                                ram_arready;
  logic [axi4_ram_pkg::data_width-1:0] ram_rdata;
  logic                                ram_rlast;
  logic                                ram_rvalid;
  logic                                ram_rready;

  axi4_wr_arbiter axi4_wr_arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mst_awaddr  (awaddr),
    .mst_awlen   (awlen),
    .mst_awvalid (awvalid),
    .mst_awready (awready),
    .mst_wdata   (wdata),
    .mst_wstrb   (wstrb),
    .mst_wlast   (wlast),
    .mst_wvalid  (wvalid),
    .mst_wready  (wready),
    .mst_bvalid  (bvalid),
    .mst_bready  (bready),
    .ram_awaddr  (ram_awaddr),
    .ram_awlen   (ram_awlen),
    .ram_awvalid (ram_awvalid),
    .ram_awready (ram_awready),
    .ram_wdata   (ram_wdata),
    .ram_wstrb   (ram_wstrb),
    .ram_wlast   (ram_wlast),
    .ram_wvalid  (ram_wvalid),
    .ram_wready  (ram_wready),
    .ram_bvalid  (ram_bvalid),
    .ram_bready  (ram_bready)
  );

  axi4_rd_arbiter axi4_rd_arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mst_araddr  (araddr),
    .mst_arlen   (arlen),
    .mst_arvalid (arvalid),
    .mst_arready (arready),
    .mst_rdata   (rdata),
    .mst_rlast   (rlast),
    .mst_rvalid  (rvalid),
    .mst_rready  (rready),
    .ram_araddr  (ram_araddr),
    .ram_arlen   (ram_arlen),
    .ram_arvalid (ram_arvalid),
    .ram_arready (ram_arready),
    .ram_rdata   (ram_rdata),
    .ram_rlast   (ram_rlast),
    .ram_rvalid  (ram_rvalid),
    .ram_rready  (ram_rready)
  );

  // Both engines run side by side
  axi4_ram_slave axi4_ram_slave_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (ram_awaddr),
    .awlen   (ram_awlen),
    .awvalid (ram_awvalid),
    .awready (ram_awready),
    .wdata   (ram_wdata),
    .wstrb   (ram_wstrb),
    .wlast   (ram_wlast),
    .wvalid  (ram_wvalid),
    .wready  (ram_wready),
    .bvalid  (ram_bvalid),
    .bready  (ram_bready),
    .araddr  (ram_araddr),
    .arlen   (ram_arlen),
    .arvalid (ram_arvalid),
    .arready (ram_arready),
    .rdata   (ram_rdata),
    .rlast   (ram_rlast),
    .rvalid  (ram_rvalid),
    .rready  (ram_rready)
  );

endmodule

//--- hw/axi4_ram_slave.sv
// AXI4 slave word RAM with separate write and read burst engines
module axi4_ram_slave (
  input  logic clk,
  input  logic rst_n,

  // Write side
  input  logic [axi4_ram_pkg::addr_width-1:0] awaddr,
  input  logic [axi4_ram_pkg::len_width-1:0]  awlen,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [axi4_ram_pkg::data_width-1:0] wdata,
  input  logic [axi4_ram_pkg::strb_width-1:0] wstrb,
  input  logic                                wlast,
  input  logic                                wvalid,
  output logic                                wready,
  output logic                                bvalid,
  input  logic                                bready,

  // Read side
  input  logic [axi4_ram_pkg::addr_width-1:0] araddr,
  input  logic [axi4_ram_pkg::len_width-1:0]  arlen,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [axi4_ram_pkg::data_width-1:0] rdata,
  output logic                                rlast,
  output logic                                rvalid,
  input  logic                                rready
);

  // Word array
  logic [axi4_ram_pkg::data_width-1:0] mem [axi4_ram_pkg::ram_words];

  axi4_ram_pkg::ram_wr_state_e          wr_state;
  logic [axi4_ram_pkg::ram_idx_width-1:0] wr_idx;
  logic [axi4_ram_pkg::len_width-1:0]     wr_len;
  logic [axi4_ram_pkg::len_width-1:0]     wr_cnt;
  logic                                   wr_beat;

  axi4_ram_pkg::ram_rd_state_e          rd_state;
  logic [axi4_ram_pkg::ram_idx_width-1:0] rd_idx;
  logic [axi4_ram_pkg::len_width-1:0]     rd_len;
  logic [axi4_ram_pkg::len_width-1:0]     rd_cnt;

  // ----------------------------------------------------------------------
  // Write engine
  // ----------------------------------------------------------------------
  assign awready = (wr_state == axi4_ram_pkg::ram_wr_addr_e);
  assign wready  = (wr_state == axi4_ram_pkg::ram_wr_data_e);
  assign bvalid  = (wr_state == axi4_ram_pkg::ram_wr_resp_e);
  assign wr_beat = wvalid && wready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= axi4_ram_pkg::ram_wr_addr_e;
      wr_idx   <= '0;
      wr_len   <= '0;
      wr_cnt   <= '0;
    end else begin
      case (wr_state)
        axi4_ram_pkg::ram_wr_addr_e: begin
          if (awvalid) begin
            // Drop the byte offset
            wr_idx   <= awaddr[axi4_ram_pkg::addr_width-1:2];
            wr_len   <= awlen;
            wr_cnt   <= '0;
            wr_state <= axi4_ram_pkg::ram_wr_data_e;
          end
        end
        axi4_ram_pkg::ram_wr_data_e: begin
          if (wr_beat) begin
            // Index wraps at the top of the array
            wr_idx <= wr_idx + 1'b1;
            wr_cnt <= wr_cnt + 1'b1;
            // wlast closes the burst, the length is a backstop
            if (wlast || wr_cnt == wr_len) begin
              wr_state <= axi4_ram_pkg::ram_wr_resp_e;
            end
          end
        end
        axi4_ram_pkg::ram_wr_resp_e: begin
          if (bready) begin
            wr_state <= axi4_ram_pkg::ram_wr_addr_e;
          end
        end
        default: wr_state <= axi4_ram_pkg::ram_wr_addr_e;
      endcase
    end
  end

  // Byte-masked store
  always_ff @(posedge clk) begin
    if (wr_beat) begin
      for (int b = 0; b < axi4_ram_pkg::strb_width; b++) begin
        if (wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read engine
  // ----------------------------------------------------------------------
  assign arready = (rd_state == axi4_ram_pkg::ram_rd_addr_e);
  assign rvalid  = (rd_state == axi4_ram_pkg::ram_rd_data_e);
  // Beat arlen is the last, counting from zero
  assign rlast   = rvalid && (rd_cnt == rd_len);
  assign rdata   = mem[rd_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= axi4_ram_pkg::ram_rd_addr_e;
      rd_idx   <= '0;
      rd_len   <= '0;
      rd_cnt   <= '0;
    end else begin
      case (rd_state)
        axi4_ram_pkg::ram_rd_addr_e: begin
          if (arvalid) begin
            rd_idx   <= araddr[axi4_ram_pkg::addr_width-1:2];
            rd_len   <= arlen;
            rd_cnt   <= '0;
            rd_state <= axi4_ram_pkg::ram_rd_data_e;
          end
        end
        axi4_ram_pkg::ram_rd_data_e: begin
          // Beat holds while rready is low
          if (rready) begin
            rd_idx <= rd_idx + 1'b1;
            rd_cnt <= rd_cnt + 1'b1;
            if (rlast) begin
              rd_state <= axi4_ram_pkg::ram_rd_addr_e;
            end
          end
        end
        default: rd_state <= axi4_ram_pkg::ram_rd_addr_e;
      endcase
    end
  end

endmodule

//--- hw/axi4_rd_arbiter.sv
// Round-robin read arbiter for the AR and R channels
module axi4_rd_arbiter (
  input  logic clk,
  input  logic rst_n,

  // Masters, AR
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::addr_width-1:0] mst_araddr,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::len_width-1:0]  mst_arlen,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_arvalid,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_arready,
  // Masters, R
  output logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::data_width-1:0] mst_rdata,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_rlast,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_rvalid,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_rready,

  // RAM side
  output logic [axi4_ram_pkg::addr_width-1:0] ram_araddr,
  output logic [axi4_ram_pkg::len_width-1:0]  ram_arlen,
  output logic                                ram_arvalid,
  input  logic                                ram_arready,
  input  logic [axi4_ram_pkg::data_width-1:0] ram_rdata,
  input  logic                                ram_rlast,
  input  logic                                ram_rvalid,
  output logic                                ram_rready
);

  axi4_ram_pkg::rd_arb_state_e state;

  logic [axi4_ram_pkg::mst_idx_width-1:0] ptr;
  logic [axi4_ram_pkg::mst_idx_width-1:0] sel;
  logic                                   granted;

  assign granted = (state == axi4_ram_pkg::rd_wait_last_e);

  // ----------------------------------------------------------------------
  // Grant FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= axi4_ram_pkg::rd_find_e;
      ptr   <= '0;
      sel   <= '0;
    end else begin
      case (state)
        axi4_ram_pkg::rd_find_e: begin
          // Scan read address valids
          if (ptr == axi4_ram_pkg::nr_of_masters - 1) begin
            ptr <= '0;
          end else begin
            ptr <= ptr + 1'b1;
          end
          if (mst_arvalid[ptr]) begin
            sel   <= ptr;
            state <= axi4_ram_pkg::rd_wait_last_e;
          end
        end
        axi4_ram_pkg::rd_wait_last_e: begin
          // Last beat accepted by the owner
          if (ram_rvalid && ram_rlast && mst_rready[sel]) begin
            state <= axi4_ram_pkg::rd_find_e;
          end
        end
        default: state <= axi4_ram_pkg::rd_find_e;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Channel mux
  // ----------------------------------------------------------------------
  always_comb begin
    // Data and last are broadcast, the valid alone is steered
    for (int i = 0; i < axi4_ram_pkg::nr_of_masters; i++) begin
      mst_rdata[i] = ram_rdata;
      mst_rlast[i] = ram_rlast;
    end
    ram_araddr  = '0;
    ram_arlen   = '0;
    ram_arvalid = 1'b0;
    ram_rready  = 1'b0;
    mst_arready = '0;
    mst_rvalid  = '0;
    if (granted) begin
      ram_araddr       = mst_araddr[sel];
      ram_arlen        = mst_arlen[sel];
      ram_arvalid      = mst_arvalid[sel];
      ram_rready       = mst_rready[sel];
      mst_arready[sel] = ram_arready;
      mst_rvalid[sel]  = ram_rvalid;
    end
  end

endmodule

//--- hw/axi4_wr_arbiter.sv
// Round-robin write arbiter for the AW, W and B channels
module axi4_wr_arbiter (
  input  logic clk,
  input  logic rst_n,

  // Masters, AW
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::addr_width-1:0] mst_awaddr,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::len_width-1:0]  mst_awlen,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_awvalid,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_awready,
  // Masters, W
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::data_width-1:0] mst_wdata,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0][axi4_ram_pkg::strb_width-1:0] mst_wstrb,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_wlast,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_wvalid,
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_wready,
  // Masters, B
  output logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_bvalid,
  input  logic [axi4_ram_pkg::nr_of_masters-1:0]                               mst_bready,

  // RAM side
  output logic [axi4_ram_pkg::addr_width-1:0] ram_awaddr,
  output logic [axi4_ram_pkg::len_width-1:0]  ram_awlen,
  output logic                                ram_awvalid,
  input  logic                                ram_awready,
  output logic [axi4_ram_pkg::data_width-1:0] ram_wdata,
  output logic [axi4_ram_pkg::strb_width-1:0] ram_wstrb,
  output logic                                ram_wlast,
  output logic                                ram_wvalid,
  input  logic                                ram_wready,
  input  logic                                ram_bvalid,
  output logic                                ram_bready
);

  axi4_ram_pkg::wr_arb_state_e state;

  // Rotating scan pointer and the latched grant
  logic [axi4_ram_pkg::mst_idx_width-1:0] ptr;
  logic [axi4_ram_pkg::mst_idx_width-1:0] sel;
  logic                                   granted;

  assign granted = (state == axi4_ram_pkg::wr_wait_resp_e);

  // ----------------------------------------------------------------------
  // Grant FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= axi4_ram_pkg::wr_find_e;
      ptr   <= '0;
      sel   <= '0;
    end else begin
      case (state)
        axi4_ram_pkg::wr_find_e: begin
          // One master tested per cycle
          if (ptr == axi4_ram_pkg::nr_of_masters - 1) begin
            ptr <= '0;
          end else begin
            ptr <= ptr + 1'b1;
          end
          if (mst_awvalid[ptr]) begin
            sel   <= ptr;
            state <= axi4_ram_pkg::wr_wait_resp_e;
          end
        end
        axi4_ram_pkg::wr_wait_resp_e: begin
          // Released on the B handshake
          if (ram_bvalid && mst_bready[sel]) begin
            state <= axi4_ram_pkg::wr_find_e;
          end
        end
        default: state <= axi4_ram_pkg::wr_find_e;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Channel mux
  // ----------------------------------------------------------------------
  always_comb begin
    // Idle bus, nothing visible to any master
    ram_awaddr  = '0;
    ram_awlen   = '0;
    ram_awvalid = 1'b0;
    ram_wdata   = '0;
    ram_wstrb   = '0;
    ram_wlast   = 1'b0;
    ram_wvalid  = 1'b0;
    ram_bready  = 1'b0;
    mst_awready = '0;
    mst_wready  = '0;
    mst_bvalid  = '0;
    if (granted) begin
      // Forward path
      ram_awaddr       = mst_awaddr[sel];
      ram_awlen        = mst_awlen[sel];
      ram_awvalid      = mst_awvalid[sel];
      ram_wdata        = mst_wdata[sel];
      ram_wstrb        = mst_wstrb[sel];
      ram_wlast        = mst_wlast[sel];
      ram_wvalid       = mst_wvalid[sel];
      ram_bready       = mst_bready[sel];
      // Return path, granted master only
      mst_awready[sel] = ram_awready;
      mst_wready[sel]  = ram_wready;
      mst_bvalid[sel]  = ram_bvalid;
    end
  end

endmodule

//--- hw/axi4_ram_pkg.sv
// Shared bus widths, master count, RAM depth and FSM state enums
package axi4_ram_pkg;

  // ----------------------------------------------------------------------
  // Masters
  // ----------------------------------------------------------------------
  localparam int nr_of_masters = 4;
  localparam int mst_idx_width = 2;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int addr_width = 8;
  localparam int data_width = 32;
  localparam int strb_width = 4;
  // AXI4 burst length field
  localparam int len_width  = 8;

  // ----------------------------------------------------------------------
  // RAM geometry
  // ----------------------------------------------------------------------
  // Byte address bits 7..2 pick the word
  localparam int ram_words     = 64;
  localparam int ram_idx_width = 6;

  // ----------------------------------------------------------------------
  // FSM states
  // ----------------------------------------------------------------------
  // Write arbiter, grant held until the B handshake
  typedef enum logic {
    wr_find_e,
    wr_wait_resp_e
  } wr_arb_state_e;

  // Read arbiter, grant held until the last R beat
  typedef enum logic {
    rd_find_e,
    rd_wait_last_e
  } rd_arb_state_e;

  // RAM write engine
  typedef enum logic [1:0] {
    ram_wr_addr_e,
    ram_wr_data_e,
    ram_wr_resp_e
  } ram_wr_state_e;

  // RAM read engine
  typedef enum logic {
    ram_rd_addr_e,
    ram_rd_data_e
  } ram_rd_state_e;

endpackage
